// ==== design/rv_pkg.sv ====
package rv_pkg;

	// architectural widths
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	// major opcodes handled by this slice
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111
	} opcode_e;

	// funct3 field of OP and OP_IMM
	typedef enum logic [2:0] {
		F3_ADD_SUB = 3'b000,
		F3_SLL     = 3'b001,
		F3_SLT     = 3'b010,
		F3_SLTU    = 3'b011,
		F3_XOR     = 3'b100,
		F3_SRL_SRA = 3'b101,
		F3_OR      = 3'b110,
		F3_AND     = 3'b111
	} funct3_e;

	// funct7 field, alt selects sub and sra
	typedef enum logic [6:0] {
		F7_BASE = 7'b0000000,
		F7_ALT  = 7'b0100000
	} funct7_e;

	// operations of the execute stage
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLL    = 4'd2,
		ALU_SLT    = 4'd3,
		ALU_SLTU   = 4'd4,
		ALU_XOR    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_OR     = 4'd8,
		ALU_AND    = 4'd9,
		// operand 2 straight through, for lui
		ALU_PASS_B = 4'd10
	} alu_op_e;

endpackage

// ==== design/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
	input  logic        clk,
	input  logic        rst,
	input  logic [4:0]  raddr1,
	input  logic [4:0]  raddr2,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2,
	input  logic        we,
	input  logic [4:0]  waddr,
	input  logic [31:0] wdata
);

	// x0 has no storage
	logic [31:0] regs [1:31];

	// x0 reads zero, a same-cycle write is bypassed
	function automatic logic [31:0] read_port(input logic [4:0] addr);
		if (addr == 5'd0) begin
			return '0;
		end
		if (we && (waddr == addr)) begin
			return wdata;
		end
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (waddr != 5'd0)) begin
			regs[waddr] <= wdata;
		end
	end

	always_comb begin
		rdata1 = read_port(raddr1);
		rdata2 = read_port(raddr2);
	end

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
	input  logic [rv_pkg::XLEN-1:0]       inst,
	input  logic [rv_pkg::XLEN-1:0]       inst_pc,
	output logic [rv_pkg::REG_ADDR_W-1:0] raddr1,
	output logic [rv_pkg::REG_ADDR_W-1:0] raddr2,
	input  logic [rv_pkg::XLEN-1:0]       rdata1,
	input  logic [rv_pkg::XLEN-1:0]       rdata2,
	output logic [rv_pkg::XLEN-1:0]       dec_pc,
	output logic [rv_pkg::REG_ADDR_W-1:0] dec_rd,
	output logic [rv_pkg::REG_ADDR_W-1:0] dec_rs1,
	output logic [rv_pkg::REG_ADDR_W-1:0] dec_rs2,
	output logic                          dec_uses_rs1,
	output logic                          dec_uses_rs2,
	output logic                          dec_reg_write,
	output rv_pkg::alu_op_e               dec_alu_op,
	output logic [rv_pkg::XLEN-1:0]       dec_operand1,
	output logic [rv_pkg::XLEN-1:0]       dec_operand2
);

	import rv_pkg::*;

	opcode_e         opcode;
	funct3_e         funct3;
	logic [6:0]      funct7;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_u;
	logic            supported;

	// funct3 to op when funct7 is the base encoding
	function automatic alu_op_e base_op(input funct3_e f3);
		case (f3)
			F3_ADD_SUB: return ALU_ADD;
			F3_SLL:     return ALU_SLL;
			F3_SLT:     return ALU_SLT;
			F3_SLTU:    return ALU_SLTU;
			F3_XOR:     return ALU_XOR;
			F3_SRL_SRA: return ALU_SRL;
			F3_OR:      return ALU_OR;
			default:    return ALU_AND;
		endcase
	endfunction

	assign opcode = opcode_e'(inst[6:0]);
	assign funct3 = funct3_e'(inst[14:12]);
	assign funct7 = inst[31:25];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_u = {inst[31:12], 12'b0};

	assign raddr1  = inst[19:15];
	assign raddr2  = inst[24:20];
	assign dec_rs1 = inst[19:15];
	assign dec_rs2 = inst[24:20];
	assign dec_rd  = inst[11:7];
	assign dec_pc  = inst_pc;

	assign dec_operand1 = rdata1;

	always_comb begin
		supported    = 1'b0;
		dec_alu_op   = ALU_ADD;
		dec_uses_rs1 = 1'b0;
		dec_uses_rs2 = 1'b0;
		dec_operand2 = imm_u;
		case (opcode)
			OP: begin
				dec_uses_rs1 = 1'b1;
				dec_uses_rs2 = 1'b1;
				dec_operand2 = rdata2;
				if (funct7 == F7_BASE) begin
					supported  = 1'b1;
					dec_alu_op = base_op(funct3);
				end else if (funct7 == F7_ALT) begin
					// only sub and sra have an alt form
					supported  = (funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA);
					dec_alu_op = (funct3 == F3_ADD_SUB) ? ALU_SUB : ALU_SRA;
				end
			end
			OP_IMM: begin
				dec_uses_rs1 = 1'b1;
				dec_operand2 = imm_i;
				dec_alu_op   = base_op(funct3);
				if (funct3 == F3_SLL) begin
					supported = (funct7 == F7_BASE);
				end else if (funct3 == F3_SRL_SRA) begin
					supported  = (funct7 == F7_BASE) || (funct7 == F7_ALT);
					dec_alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
				end else begin
					supported = 1'b1;
				end
			end
			LUI: begin
				supported  = 1'b1;
				dec_alu_op = ALU_PASS_B;
			end
			default: begin
				supported = 1'b0;
			end
		endcase
	end

	// writes to x0 are dropped here
	assign dec_reg_write = supported && (dec_rd != '0);

endmodule

// ==== design/id_ex_reg.sv ====
`timescale 1ns/1ns

module id_ex_reg (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          inst_valid,
	output logic                          inst_ready,
	input  logic [rv_pkg::XLEN-1:0]       dec_pc,
	input  logic [rv_pkg::REG_ADDR_W-1:0] dec_rd,
	input  logic [rv_pkg::REG_ADDR_W-1:0] dec_rs1,
	input  logic [rv_pkg::REG_ADDR_W-1:0] dec_rs2,
	input  logic                          dec_uses_rs1,
	input  logic                          dec_uses_rs2,
	input  logic                          dec_reg_write,
	input  rv_pkg::alu_op_e               dec_alu_op,
	input  logic [rv_pkg::XLEN-1:0]       dec_operand1,
	input  logic [rv_pkg::XLEN-1:0]       dec_operand2,
	output logic                          ex_valid,
	output logic [rv_pkg::XLEN-1:0]       ex_pc,
	output logic [rv_pkg::REG_ADDR_W-1:0] ex_rd,
	output logic                          ex_reg_write,
	output rv_pkg::alu_op_e               ex_alu_op,
	output logic [rv_pkg::XLEN-1:0]       ex_operand1,
	output logic [rv_pkg::XLEN-1:0]       ex_operand2
);

	logic ex_writes;
	logic hazard_rs1;
	logic hazard_rs2;
	logic accept;

	// producer still in EX, its result is not in the file yet
	assign ex_writes  = ex_valid && ex_reg_write;
	assign hazard_rs1 = ex_writes && dec_uses_rs1 && (dec_rs1 == ex_rd);
	assign hazard_rs2 = ex_writes && dec_uses_rs2 && (dec_rs2 == ex_rd);

	// one-cycle stall, the bubble clears the hazard
	assign inst_ready = !(hazard_rs1 || hazard_rs2);
	assign accept     = inst_valid && inst_ready;

	// control state
	always_ff @(posedge clk) begin
		if (!rst) begin
			ex_valid     <= 1'b0;
			ex_reg_write <= 1'b0;
		end else begin
			ex_valid     <= accept;
			ex_reg_write <= accept && dec_reg_write;
		end
	end

	// payload, only loaded on accept
	always_ff @(posedge clk) begin
		if (accept) begin
			ex_pc       <= dec_pc;
			ex_rd       <= dec_rd;
			ex_alu_op   <= dec_alu_op;
			ex_operand1 <= dec_operand1;
			ex_operand2 <= dec_operand2;
		end
	end

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          ex_valid,
	input  logic [rv_pkg::XLEN-1:0]       ex_pc,
	input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rd,
	input  logic                          ex_reg_write,
	input  rv_pkg::alu_op_e               ex_alu_op,
	input  logic [rv_pkg::XLEN-1:0]       ex_operand1,
	input  logic [rv_pkg::XLEN-1:0]       ex_operand2,
	output logic                          wb_valid,
	output logic [rv_pkg::XLEN-1:0]       wb_pc,
	output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
	output logic [rv_pkg::XLEN-1:0]       wb_data
);

	import rv_pkg::*;

	logic [XLEN-1:0] alu_result;
	logic [4:0]      shamt;
	logic            lt_signed;
	logic            lt_unsigned;

	assign shamt       = ex_operand2[4:0];
	assign lt_signed   = $signed(ex_operand1) < $signed(ex_operand2);
	assign lt_unsigned = ex_operand1 < ex_operand2;

	always_comb begin
		case (ex_alu_op)
			ALU_ADD:    alu_result = ex_operand1 + ex_operand2;
			ALU_SUB:    alu_result = ex_operand1 - ex_operand2;
			ALU_SLL:    alu_result = ex_operand1 << shamt;
			ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, lt_signed};
			ALU_SLTU:   alu_result = {{(XLEN-1){1'b0}}, lt_unsigned};
			ALU_XOR:    alu_result = ex_operand1 ^ ex_operand2;
			ALU_SRL:    alu_result = ex_operand1 >> shamt;
			ALU_SRA:    alu_result = $unsigned($signed(ex_operand1) >>> shamt);
			ALU_OR:     alu_result = ex_operand1 | ex_operand2;
			ALU_AND:    alu_result = ex_operand1 & ex_operand2;
			ALU_PASS_B: alu_result = ex_operand2;
			default:    alu_result = '0;
		endcase
	end

	// only writing instructions retire
	always_ff @(posedge clk) begin
		if (!rst) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= ex_valid && ex_reg_write;
		end
	end

	always_ff @(posedge clk) begin
		if (ex_valid) begin
			wb_pc   <= ex_pc;
			wb_rd   <= ex_rd;
			wb_data <= alu_result;
		end
	end

endmodule

// ==== design/int_core_slice.sv ====
`timescale 1ns/1ns

module int_core_slice (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          inst_valid,
	output logic                          inst_ready,
	input  logic [rv_pkg::XLEN-1:0]       inst,
	input  logic [rv_pkg::XLEN-1:0]       inst_pc,
	output logic                          wb_valid,
	output logic [rv_pkg::XLEN-1:0]       wb_pc,
	output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
	output logic [rv_pkg::XLEN-1:0]       wb_data
);

	import rv_pkg::*;

	// register file read side
	logic [REG_ADDR_W-1:0] raddr1;
	logic [REG_ADDR_W-1:0] raddr2;
	logic [XLEN-1:0]       rdata1;
	logic [XLEN-1:0]       rdata2;

	// decode outputs
	logic [XLEN-1:0]       dec_pc;
	logic [REG_ADDR_W-1:0] dec_rd;
	logic [REG_ADDR_W-1:0] dec_rs1;
	logic [REG_ADDR_W-1:0] dec_rs2;
	logic                  dec_uses_rs1;
	logic                  dec_uses_rs2;
	logic                  dec_reg_write;
	alu_op_e               dec_alu_op;
	logic [XLEN-1:0]       dec_operand1;
	logic [XLEN-1:0]       dec_operand2;

	// ID/EX outputs
	logic                  ex_valid;
	logic [XLEN-1:0]       ex_pc;
	logic [REG_ADDR_W-1:0] ex_rd;
	logic                  ex_reg_write;
	alu_op_e               ex_alu_op;
	logic [XLEN-1:0]       ex_operand1;
	logic [XLEN-1:0]       ex_operand2;

	decode_stage u_decode (
		.inst         (inst),
		.inst_pc      (inst_pc),
		.raddr1       (raddr1),
		.raddr2       (raddr2),
		.rdata1       (rdata1),
		.rdata2       (rdata2),
		.dec_pc       (dec_pc),
		.dec_rd       (dec_rd),
		.dec_rs1      (dec_rs1),
		.dec_rs2      (dec_rs2),
		.dec_uses_rs1 (dec_uses_rs1),
		.dec_uses_rs2 (dec_uses_rs2),
		.dec_reg_write(dec_reg_write),
		.dec_alu_op   (dec_alu_op),
		.dec_operand1 (dec_operand1),
		.dec_operand2 (dec_operand2)
	);

	// written straight from the EX/WB register
	reg_file u_reg_file (
		.clk   (clk),
		.rst   (rst),
		.raddr1(raddr1),
		.raddr2(raddr2),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.we    (wb_valid),
		.waddr (wb_rd),
		.wdata (wb_data)
	);

	id_ex_reg u_id_ex (
		.clk          (clk),
		.rst          (rst),
		.inst_valid   (inst_valid),
		.inst_ready   (inst_ready),
		.dec_pc       (dec_pc),
		.dec_rd       (dec_rd),
		.dec_rs1      (dec_rs1),
		.dec_rs2      (dec_rs2),
		.dec_uses_rs1 (dec_uses_rs1),
		.dec_uses_rs2 (dec_uses_rs2),
		.dec_reg_write(dec_reg_write),
		.dec_alu_op   (dec_alu_op),
		.dec_operand1 (dec_operand1),
		.dec_operand2 (dec_operand2),
		.ex_valid     (ex_valid),
		.ex_pc        (ex_pc),
		.ex_rd        (ex_rd),
		.ex_reg_write (ex_reg_write),
		.ex_alu_op    (ex_alu_op),
		.ex_operand1  (ex_operand1),
		.ex_operand2  (ex_operand2)
	);

	execute_stage u_execute (
		.clk         (clk),
		.rst         (rst),
		.ex_valid    (ex_valid),
		.ex_pc       (ex_pc),
		.ex_rd       (ex_rd),
		.ex_reg_write(ex_reg_write),
		.ex_alu_op   (ex_alu_op),
		.ex_operand1 (ex_operand1),
		.ex_operand2 (ex_operand2),
		.wb_valid    (wb_valid),
		.wb_pc       (wb_pc),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data)
	);

endmodule

// ==== tests/int_core_slice_chk.sv ====
`timescale 1ns/1ns

module int_core_slice_chk (
	input logic                          clk,
	input logic                          rst,
	input logic                          inst_ready,
	input logic                          wb_valid,
	input logic [rv_pkg::REG_ADDR_W-1:0] wb_rd
);

	// x0 writes are filtered in decode
	a_wb_rd_nonzero: assert property (
		@(posedge clk) disable iff (!rst) wb_valid |-> (wb_rd != '0)
	) else $error("write-back reported for x0");

	// the bubble behind a stall always clears the hazard
	a_stall_one_cycle: assert property (
		@(posedge clk) disable iff (!rst) !inst_ready |=> inst_ready
	) else $error("inst_ready low for two cycles in a row");

	a_wb_idle_after_reset: assert property (
		@(posedge clk) !rst |=> !wb_valid
	) else $error("wb_valid high right after reset");

endmodule

bind int_core_slice int_core_slice_chk chk0 (
	.clk       (clk),
	.rst       (rst),
	.inst_ready(inst_ready),
	.wb_valid  (wb_valid),
	.wb_rd     (wb_rd)
);

// ==== tests/int_core_slice_tb.sv ====
`timescale 1ns/1ns

module int_core_slice_tb;

	localparam int unsigned SEED         = 29;
	localparam int unsigned NUM_INST     = 400;
	localparam int unsigned ACCEPT_LIMIT = 8;
	localparam int unsigned DRAIN_LIMIT  = 16;

	// major opcodes and a few this slice does not execute
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_IMM    = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	logic        clk;
	logic        rst;
	logic        inst_valid;
	logic        inst_ready;
	logic [31:0] inst;
	logic [31:0] inst_pc;
	logic        wb_valid;
	logic [31:0] wb_pc;
	logic [4:0]  wb_rd;
	logic [31:0] wb_data;

	// architectural state and expected retirements
	logic [31:0] model_regs [0:31];
	logic [31:0] exp_pc [$];
	logic [4:0]  exp_rd [$];
	logic [31:0] exp_data [$];
	int unsigned exp_cycle [$];

	int unsigned cycle = 0;
	int unsigned value_errors = 0;
	int unsigned other_errors = 0;
	int unsigned run_errors;
	int unsigned stall_count = 0;
	int unsigned skipped_count = 0;
	int unsigned retired_count = 0;
	logic        idle_checked = 1'b0;
	logic        prev_wrote = 1'b0;
	logic [4:0]  prev_rd = '0;
	logic [31:0] next_pc;

	int_core_slice dut0 (
		.clk       (clk),
		.rst       (rst),
		.inst_valid(inst_valid),
		.inst_ready(inst_ready),
		.inst      (inst),
		.inst_pc   (inst_pc),
		.wb_valid  (wb_valid),
		.wb_pc     (wb_pc),
		.wb_rd     (wb_rd),
		.wb_data   (wb_data)
	);

	always #20 clk = ~clk;

	// small register range so dependences come often
	function automatic logic [31:0] gen_inst();
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [11:0] imm;
		int unsigned kind;
		rd   = 5'($urandom % 8);
		rs1  = 5'($urandom % 8);
		rs2  = 5'($urandom % 8);
		f3   = 3'($urandom % 8);
		imm  = 12'($urandom);
		kind = $urandom % 16;
		if (kind < 6) begin
			f7 = ((f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2 == 1)) ? 7'h20 : 7'h00;
			return {f7, rs2, rs1, f3, rd, OPC_OP};
		end else if (kind < 11) begin
			if (f3 == 3'd1) begin
				imm[11:5] = 7'h00;
			end else if (f3 == 3'd5) begin
				imm[11:5] = ($urandom % 2 == 1) ? 7'h20 : 7'h00;
			end
			return {imm, rs1, f3, rd, OPC_IMM};
		end else if (kind < 14) begin
			return {20'($urandom), rd, OPC_LUI};
		end else if (kind == 14) begin
			// multiply encoding from the M extension
			return {7'h01, rs2, rs1, f3, rd, OPC_OP};
		end
		return {25'($urandom), ($urandom % 2 == 1) ? OPC_LOAD : OPC_BRANCH};
	endfunction

	// RV32I semantics of the supported subset
	function automatic void model_exec(input logic [31:0] word, output logic writes,
		output logic [4:0] rd, output logic [31:0] result);
		logic [6:0]  opcode;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] a;
		logic [31:0] b;
		logic        alt;
		logic        legal;
		opcode = word[6:0];
		f3     = word[14:12];
		f7     = word[31:25];
		rd     = word[11:7];
		a      = model_regs[word[19:15]];
		b      = (opcode == OPC_OP) ? model_regs[word[24:20]] : {{20{word[31]}}, word[31:20]};
		alt    = (f7 == 7'h20);
		legal  = 1'b0;
		result = '0;
		if (opcode == OPC_LUI) begin
			legal  = 1'b1;
			result = {word[31:12], 12'h000};
		end else if (opcode == OPC_OP || opcode == OPC_IMM) begin
			if (opcode == OPC_OP) begin
				legal = (f7 == 7'h00) || (alt && (f3 == 3'd0 || f3 == 3'd5));
			end else if (f3 == 3'd1) begin
				legal = (f7 == 7'h00);
			end else if (f3 == 3'd5) begin
				legal = (f7 == 7'h00) || alt;
			end else begin
				legal = 1'b1;
			end
			case (f3)
				3'd0: result = (opcode == OPC_OP && alt) ? a - b : a + b;
				3'd1: result = a << b[4:0];
				3'd2: result = {31'd0, $signed(a) < $signed(b)};
				3'd3: result = {31'd0, a < b};
				3'd4: result = a ^ b;
				3'd5: begin
					if (alt) begin
						result = $signed(a) >>> b[4:0];
					end else begin
						result = a >> b[4:0];
					end
				end
				3'd6: result = a | b;
				default: result = a & b;
			endcase
		end
		writes = legal && (rd != 5'd0);
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			value_errors++;
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	// present one instruction and hold it until accepted
	task automatic send_inst(input logic [31:0] word, output logic accepted);
		int unsigned wait_cycles;
		inst_valid <= 1'b1;
		inst       <= word;
		inst_pc    <= next_pc;
		wait_cycles = 0;
		@(posedge clk);
		while (!inst_ready && wait_cycles < ACCEPT_LIMIT) begin
			wait_cycles++;
			@(posedge clk);
		end
		accepted = inst_ready;
		if (!accepted) begin
			$display("timeout: instruction at pc %h was never accepted", next_pc);
		end
		next_pc = next_pc + 32'd4;
	endtask

	always @(posedge clk) begin : monitor
		logic        writes;
		logic [4:0]  rd;
		logic [31:0] result;
		logic        dep;
		cycle = cycle + 1;
		if (!rst) begin
			for (int i = 0; i < 32; i++) begin
				model_regs[i] = '0;
			end
			prev_wrote = 1'b0;
		end else begin
			if (!idle_checked) begin
				idle_checked = 1'b1;
				check_value("wb_valid", 32'd0, {31'd0, wb_valid});
				check_value("inst_ready", 32'd1, {31'd0, inst_ready});
			end
			if (wb_valid) begin
				if (exp_data.size() == 0) begin
					other_errors++;
					$display("write-back at %0t ns with no instruction outstanding", $time);
				end else begin
					retired_count++;
					check_value("wb_pc", exp_pc.pop_front(), wb_pc);
					check_value("wb_rd", {27'd0, exp_rd.pop_front()}, {27'd0, wb_rd});
					check_value("wb_data", exp_data.pop_front(), wb_data);
					check_value("wb_cycle", exp_cycle.pop_front(), cycle);
				end
			end
			if (inst_valid) begin
				// stall only on the rd of the instruction accepted one edge ago
				dep = prev_wrote && (
					((inst[6:0] == OPC_OP || inst[6:0] == OPC_IMM) && inst[19:15] == prev_rd) ||
					(inst[6:0] == OPC_OP && inst[24:20] == prev_rd));
				check_value("inst_ready", {31'd0, !dep}, {31'd0, inst_ready});
				if (!inst_ready) begin
					stall_count++;
				end
			end
			if (inst_valid && inst_ready) begin
				model_exec(inst, writes, rd, result);
				if (writes) begin
					model_regs[rd] = result;
					exp_pc.push_back(inst_pc);
					exp_rd.push_back(rd);
					exp_data.push_back(result);
					exp_cycle.push_back(cycle + 2);
				end else begin
					skipped_count++;
				end
				prev_wrote = writes;
				prev_rd    = rd;
			end else begin
				prev_wrote = 1'b0;
			end
		end
	end

	initial begin
		logic        accepted;
		int unsigned gap;
		int unsigned drain_cycles;
		void'($urandom(SEED));
		clk        = 1'b0;
		rst        = 1'b0;
		inst_valid = 1'b0;
		inst       = '0;
		inst_pc    = '0;
		next_pc    = 32'h0000_1000;
		run_errors = 0;
		accepted   = 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b1;
		repeat (2) @(posedge clk);
		for (int n = 0; n < NUM_INST && accepted; n++) begin
			if ($urandom % 4 == 0) begin
				inst_valid <= 1'b0;
				gap = 1 + ($urandom % 3);
				repeat (gap) @(posedge clk);
			end
			send_inst(gen_inst(), accepted);
		end
		inst_valid <= 1'b0;
		drain_cycles = 0;
		while (exp_data.size() != 0 && drain_cycles < DRAIN_LIMIT) begin
			drain_cycles++;
			@(posedge clk);
		end
		// a spurious late write-back would still show up here
		repeat (4) @(posedge clk);
		if (!accepted) begin
			run_errors++;
		end
		if (exp_data.size() != 0) begin
			run_errors++;
			$display("%0d instructions never retired", exp_data.size());
		end
		if (stall_count == 0 || skipped_count == 0) begin
			run_errors++;
			$display("stimulus produced no stall or no non-writing instruction");
		end
		$display("value errors %0d, protocol errors %0d, run errors %0d, retired %0d, stalls %0d",
			value_errors, other_errors, run_errors, retired_count, stall_count);
		if (value_errors + other_errors + run_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== int_core_slice.f ====
design/rv_pkg.sv
design/reg_file.sv
design/decode_stage.sv
design/id_ex_reg.sv
design/execute_stage.sv
design/int_core_slice.sv
tests/int_core_slice_chk.sv
tests/int_core_slice_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the int_core_slice testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module int_core_slice_tb \
	-f int_core_slice.f \
	-o int_core_slice_sim

./obj_dir/int_core_slice_sim | tee sim.log

if grep -q "Testbench failed" sim.log; then
	echo "simulation reported failure, see sim.log"
	exit 1
fi

echo "simulation finished without failure"
